//--- include/message_text.svh
`ifndef MESSAGE_TEXT_SVH
`define MESSAGE_TEXT_SVH

// Text ROM image as one 1024-bit vector.
// Address 0 sits in the most significant byte, so byte a is
// image[8*(127-a) +: 8].
//
//   0x00..0x0F  hex glyphs
//   0x10..0x4F  boot title, 55 characters incl. CR LF, space padded
//   0x50..0x7F  user title, 12 characters, space padded
//
// Unused entries are spaces.

`define MESSAGE_TEXT_IMAGE { \
    "0123456789ABCDEF", \
    "Bubble memory boot loader area, 30 lines of 16 bytes:", \
    8'h0D, \
    8'h0A, \
    {9{8'h20}}, \
    "USER PAGE 0x", \
    {36{8'h20}} \
}

`endif

//--- design/usb_dump_pkg.sv
`default_nettype none

package usb_dump_pkg;

    // page buffer geometry
    localparam int BUF_BITS    = 8192;
    localparam int BIT_ADDR_W  = 13;
    localparam int BYTE_ADDR_W = 10;
    localparam int BUF_BYTES   = BUF_BITS / 8;

    // text ROM geometry
    localparam int TEXT_ADDR_W = 7;
    localparam int TEXT_BYTES  = 1 << TEXT_ADDR_W;

    localparam int PAGE_W = 12;                 // relative page number, three hex digits

    // dump layout
    localparam int BYTES_PER_LINE = 16;
    localparam int BOOT_LINES     = 30;
    localparam int USER_LINES     = 8;

    // text ROM map, see message_text.svh
    localparam logic [TEXT_ADDR_W-1:0] HEX_GLYPH_ADDR  = 7'h00;   // "0".."9","A".."F"
    localparam logic [TEXT_ADDR_W-1:0] BOOT_TITLE_ADDR = 7'h10;
    localparam int                     BOOT_TITLE_LEN  = 55;      // ends with CR LF
    localparam logic [TEXT_ADDR_W-1:0] USER_TITLE_ADDR = 7'h50;
    localparam int                     USER_TITLE_LEN  = 12;      // page number follows

    localparam logic [7:0] CHAR_CR    = 8'h0D;
    localparam logic [7:0] CHAR_LF    = 8'h0A;
    localparam logic [7:0] CHAR_SPACE = 8'h20;

    // one bit write into the page buffer
    typedef struct packed {
        logic                  en;
        logic [BIT_ADDR_W-1:0] addr;    // [12:3] byte, [2:0] bit, 0 is the LSB
        logic                  data;
    } buf_wr_t;

    // one character on a valid/ready link
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } char_t;

endpackage

`default_nettype wire

//--- design/page_bit_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module page_bit_buffer import usb_dump_pkg::*; (
    input  wire logic                   MCLK,
    input  wire buf_wr_t                buf_wr,
    input  wire logic                   rd_en,
    input  wire logic [BYTE_ADDR_W-1:0] rd_addr,
    output logic      [7:0]             rd_data
);

    logic [7:0]             mem [BUF_BYTES];
    logic [BYTE_ADDR_W-1:0] wr_byte;
    logic [7:0]             wr_word;

    assign wr_byte = buf_wr.addr[BIT_ADDR_W-1:3];

    // merge the new bit into the stored byte
    always_comb begin
        wr_word = mem[wr_byte];
        wr_word[buf_wr.addr[2:0]] = buf_wr.data;
    end

    always_ff @(posedge MCLK) begin
        if (buf_wr.en) begin
            mem[wr_byte] <= wr_word;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];        // held until the next read strobe
        end
    end

endmodule

`default_nettype wire

//--- design/text_rom.sv
`timescale 1ns/100ps
`default_nettype none

module text_rom import usb_dump_pkg::*; (
    input  wire logic                   MCLK,
    input  wire logic                   rd_en,
    input  wire logic [TEXT_ADDR_W-1:0] addr,
    output logic      [7:0]             data
);

    `include "message_text.svh"

    logic [8*TEXT_BYTES-1:0] image;
    logic [7:0]              rom [TEXT_BYTES];

    initial begin
        image = `MESSAGE_TEXT_IMAGE;
        for (int i = 0; i < TEXT_BYTES; i++) begin
            rom[i] = image[8*(TEXT_BYTES-1-i) +: 8];    // first character is the MSB
        end
    end

    always_ff @(posedge MCLK) begin
        if (rd_en) begin
            data <= rom[addr];
        end
    end

endmodule

`default_nettype wire

//--- design/dump_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module dump_sequencer import usb_dump_pkg::*; (
    input  wire logic                   MCLK,
    input  wire logic                   arst_n,
    input  wire logic                   fifo_en,
    input  wire logic                   send_boot,
    input  wire logic                   send_user,
    input  wire logic [PAGE_W-1:0]      rel_page,
    output logic                        buf_rd_en,
    output logic      [BYTE_ADDR_W-1:0] buf_rd_addr,
    input  wire logic [7:0]             buf_rd_data,
    output logic                        rom_rd_en,
    output logic      [TEXT_ADDR_W-1:0] rom_addr,
    input  wire logic [7:0]             rom_data,
    output char_t                       seq_char,
    input  wire logic                   seq_ready,
    output logic                        flush
);

    typedef enum logic [3:0] {
        S_IDLE, S_TITLE_RD, S_TITLE_PUT, S_PAGE_RD, S_PAGE_PUT,
        S_BYTE_RD, S_HI_RD, S_HI_PUT, S_LO_RD, S_LO_PUT,
        S_SPACE, S_CR, S_LF, S_WAIT_REL
    } seq_state_t;

    seq_state_t             state;
    logic                   is_boot;            // latched dump kind
    logic [TEXT_ADDR_W-1:0] title_ptr;
    logic [5:0]             title_left;         // characters after the current one
    logic [1:0]             nib;                // page digit, 2 is the high one
    logic [BYTE_ADDR_W-1:0] byte_addr;
    logic [3:0]             byte_cnt;
    logic [4:0]             line_cnt;
    logic [4:0]             line_total;
    logic                   closing;            // the final CR LF is under way
    logic [3:0]             page_nibble;
    logic                   emit;
    logic [7:0]             emit_char;
    logic                   step;
    logic                   abort;

    assign line_total  = is_boot ? 5'(BOOT_LINES) : 5'(USER_LINES);
    assign page_nibble = rel_page[4*nib +: 4];
    assign buf_rd_addr = byte_addr;

    // output slot is free when empty or being taken this cycle
    assign step  = emit && (!seq_char.valid || seq_ready);
    assign abort = (state != S_IDLE) && (state != S_WAIT_REL) && !send_boot && !send_user;

    // read strobes and the character offered in each state
    always_comb begin
        emit      = 1'b0;
        emit_char = CHAR_SPACE;
        rom_rd_en = 1'b0;
        rom_addr  = title_ptr;
        buf_rd_en = 1'b0;
        case (state)
            S_TITLE_RD: rom_rd_en = 1'b1;
            S_PAGE_RD: begin
                rom_rd_en = 1'b1;
                rom_addr  = HEX_GLYPH_ADDR + TEXT_ADDR_W'(page_nibble);
            end
            S_BYTE_RD: buf_rd_en = 1'b1;
            S_HI_RD: begin
                rom_rd_en = 1'b1;
                rom_addr  = HEX_GLYPH_ADDR + TEXT_ADDR_W'(buf_rd_data[7:4]);
            end
            S_LO_RD: begin
                rom_rd_en = 1'b1;
                rom_addr  = HEX_GLYPH_ADDR + TEXT_ADDR_W'(buf_rd_data[3:0]);
            end
            S_TITLE_PUT, S_PAGE_PUT, S_HI_PUT, S_LO_PUT: begin
                emit      = 1'b1;
                emit_char = rom_data;   // ROM output holds while no read is strobed
            end
            S_SPACE: emit = 1'b1;
            S_CR: begin
                emit      = 1'b1;
                emit_char = CHAR_CR;
            end
            S_LF: begin
                emit      = 1'b1;
                emit_char = CHAR_LF;
            end
            default: ;
        endcase
    end

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            seq_char   <= '0;
            flush      <= 1'b0;
            is_boot    <= 1'b0;
            title_ptr  <= '0;
            title_left <= '0;
            nib        <= '0;
            byte_addr  <= '0;
            byte_cnt   <= '0;
            line_cnt   <= '0;
            closing    <= 1'b0;
        end else begin
            flush <= 1'b0;
            if (step) begin
                seq_char <= '{valid: 1'b1, data: emit_char};
            end else if (seq_ready) begin
                seq_char.valid <= 1'b0;
            end

            if (abort) begin                    // requests released mid-dump
                state          <= S_IDLE;
                seq_char.valid <= 1'b0;
                flush          <= 1'b1;
            end else begin
                case (state)
                    S_IDLE: if (fifo_en && (send_boot || send_user)) begin
                        is_boot    <= send_boot;    // boot wins when both are set
                        title_ptr  <= send_boot ? BOOT_TITLE_ADDR : USER_TITLE_ADDR;
                        title_left <= send_boot ? 6'(BOOT_TITLE_LEN - 1) : 6'(USER_TITLE_LEN - 1);
                        nib        <= 2'd2;
                        byte_addr  <= '0;
                        byte_cnt   <= '0;
                        line_cnt   <= '0;
                        closing    <= 1'b0;
                        state      <= S_TITLE_RD;
                    end
                    S_TITLE_RD: state <= S_TITLE_PUT;
                    S_TITLE_PUT: if (step) begin
                        title_ptr  <= title_ptr + 1'b1;
                        title_left <= title_left - 1'b1;
                        if (title_left == '0) begin
                            state <= is_boot ? S_BYTE_RD : S_PAGE_RD;
                        end else begin
                            state <= S_TITLE_RD;
                        end
                    end
                    S_PAGE_RD: state <= S_PAGE_PUT;
                    S_PAGE_PUT: if (step) begin
                        nib   <= nib - 1'b1;
                        state <= (nib == 2'd0) ? S_CR : S_PAGE_RD;
                    end
                    S_BYTE_RD: state <= S_HI_RD;
                    S_HI_RD:   state <= S_HI_PUT;
                    S_HI_PUT:  if (step) state <= S_LO_RD;
                    S_LO_RD:   state <= S_LO_PUT;
                    S_LO_PUT:  if (step) state <= S_SPACE;
                    S_SPACE: if (step) begin
                        byte_addr <= byte_addr + 1'b1;
                        byte_cnt  <= byte_cnt + 1'b1;   // wraps at the line end
                        if (byte_cnt == 4'(BYTES_PER_LINE - 1)) begin
                            line_cnt <= line_cnt + 1'b1;
                            state    <= S_CR;
                        end else begin
                            state <= S_BYTE_RD;
                        end
                    end
                    S_CR: if (step) state <= S_LF;
                    S_LF: if (step) begin
                        if (closing) begin
                            state <= S_WAIT_REL;
                        end else if (line_cnt == line_total) begin
                            closing <= 1'b1;            // one more CR LF closes the dump
                            state   <= S_CR;
                        end else begin
                            state <= S_BYTE_RD;
                        end
                    end
                    S_WAIT_REL: if (!send_boot && !send_user) state <= S_IDLE;
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/fifo_tx_queue.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_tx_queue import usb_dump_pkg::*; (
    input  wire logic  MCLK,
    input  wire logic  arst_n,
    input  wire char_t seq_char,
    output logic       seq_ready,
    input  wire logic  flush,
    output char_t      tx,
    input  wire logic  tx_ready
);

    logic [1:0] count;          // 0..2 characters held
    logic [7:0] head;           // oldest character, shown on tx
    logic [7:0] tail;
    logic       push;
    logic       pop;
    logic       load_head;

    assign seq_ready = (count != 2'd2);
    assign tx        = '{valid: (count != 2'd0), data: head};
    assign push      = seq_char.valid && seq_ready;
    assign pop       = tx.valid && tx_ready;

    // new character goes straight to the head when nothing stays in front of it
    assign load_head = push && ((count == 2'd0) || (pop && count == 2'd1));

    always_ff @(posedge MCLK or negedge arst_n) begin
        if (!arst_n) begin
            count <= 2'd0;
        end else if (flush) begin
            count <= 2'd0;      // drop everything on abort
        end else begin
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge MCLK) begin
        if (load_head) begin
            head <= seq_char.data;
        end else if (pop) begin
            head <= tail;
        end
        if (push && !load_head) begin
            tail <= seq_char.data;
        end
    end

endmodule

`default_nettype wire

//--- design/usb_dump_top.sv
`timescale 1ns/100ps
`default_nettype none

module usb_dump_top import usb_dump_pkg::*; (
    input  wire logic              MCLK,
    input  wire logic              arst_n,
    input  wire logic              fifo_en,
    input  wire logic              send_boot,
    input  wire logic              send_user,
    input  wire logic [PAGE_W-1:0] rel_page,
    input  wire buf_wr_t           buf_wr,
    output char_t                  tx,
    input  wire logic              tx_ready
);

    logic                   buf_rd_en;
    logic [BYTE_ADDR_W-1:0] buf_rd_addr;
    logic [7:0]             buf_rd_data;
    logic                   rom_rd_en;
    logic [TEXT_ADDR_W-1:0] rom_addr;
    logic [7:0]             rom_data;
    char_t                  seq_char;
    logic                   seq_ready;
    logic                   flush;

    page_bit_buffer u_buffer (
        .MCLK, .buf_wr,
        .rd_en(buf_rd_en), .rd_addr(buf_rd_addr), .rd_data(buf_rd_data)
    );

    text_rom u_rom (.MCLK, .rd_en(rom_rd_en), .addr(rom_addr), .data(rom_data));

    dump_sequencer u_seq (
        .MCLK, .arst_n, .fifo_en, .send_boot, .send_user, .rel_page,
        .buf_rd_en, .buf_rd_addr, .buf_rd_data,
        .rom_rd_en, .rom_addr, .rom_data,
        .seq_char, .seq_ready, .flush
    );

    fifo_tx_queue u_queue (.MCLK, .arst_n, .seq_char, .seq_ready, .flush, .tx, .tx_ready);

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic MCLK,
    output logic arst_n
);

    always begin
        MCLK = 1'b0;
        #2;
        MCLK = 1'b1;
        #2;                         // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge MCLK);
        #1;
        arst_n = 1'b1;              // released just after the fifth edge
    end

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tb_checker import usb_dump_pkg::*; (
    input  wire logic       MCLK,
    input  wire logic       send_boot,
    input  wire logic       send_user,
    input  wire char_t      tx,
    input  wire logic       tx_ready,
    input  wire logic [7:0] ref_mem [BUF_BYTES],
    output logic            dump_done
);

    `include "message_text.svh"

    logic [8*TEXT_BYTES-1:0] image;
    logic [7:0]              rom [TEXT_BYTES];
    logic [7:0]              exp_q [$];        // expected stream of the running test
    string                   test_name = "none";
    logic                    active = 1'b0;
    logic                    prefix_ok = 1'b0;  // an aborted dump only has to match a prefix
    int                      rx_cnt = 0;
    int                      test_errs = 0;
    int                      total_errs = 0;
    int                      n_pass = 0;
    int                      n_fail = 0;
    int                      rel_cycles = 0;    // falling edges seen with both requests low
    logic                    stalled = 1'b0;    // tx was held back at the last sample
    logic [7:0]              stall_data;

    initial begin
        dump_done = 1'b0;
        image     = `MESSAGE_TEXT_IMAGE;
        for (int i = 0; i < TEXT_BYTES; i++) begin
            rom[i] = image[8*(TEXT_BYTES-1-i) +: 8];
        end
    end

    function automatic logic [7:0] hex_glyph(input logic [3:0] nibble);
        return rom[int'(HEX_GLYPH_ADDR) + int'(nibble)];
    endfunction

    // expected characters for a request, following the dump layout
    function automatic void build_expected(input logic fen, input logic boot, input logic user,
                                           input logic [PAGE_W-1:0] page);
        int         base;
        int         len;
        int         lines;
        logic [7:0] b;
        exp_q.delete();
        if (!fen || (!boot && !user)) begin
            return;                                 // no dump at all
        end
        base  = boot ? int'(BOOT_TITLE_ADDR) : int'(USER_TITLE_ADDR);
        len   = boot ? BOOT_TITLE_LEN : USER_TITLE_LEN;
        lines = boot ? BOOT_LINES : USER_LINES;
        for (int i = 0; i < len; i++) begin
            exp_q.push_back(rom[base + i]);
        end
        if (!boot) begin
            for (int n = 2; n >= 0; n--) begin      // high digit first
                exp_q.push_back(hex_glyph(page[4*n +: 4]));
            end
            exp_q.push_back(CHAR_CR);
            exp_q.push_back(CHAR_LF);
        end
        for (int l = 0; l < lines; l++) begin
            for (int k = 0; k < BYTES_PER_LINE; k++) begin
                b = ref_mem[l * BYTES_PER_LINE + k];
                exp_q.push_back(hex_glyph(b[7:4]));
                exp_q.push_back(hex_glyph(b[3:0]));
                exp_q.push_back(CHAR_SPACE);
            end
            exp_q.push_back(CHAR_CR);
            exp_q.push_back(CHAR_LF);
        end
        exp_q.push_back(CHAR_CR);                   // closing line
        exp_q.push_back(CHAR_LF);
    endfunction

    function automatic void report_error(input string msg);
        $display("ERROR at %0d ns: %s in test %s", $time, msg, test_name);
        test_errs++;
        total_errs++;
    endfunction

    function automatic void start_test(input string name, input logic fen, input logic boot,
                                       input logic user, input logic [PAGE_W-1:0] page,
                                       input logic allow_prefix);
        build_expected(fen, boot, user, page);
        test_name = name;
        prefix_ok = allow_prefix;
        active    = 1'b1;
        rx_cnt    = 0;
        test_errs = 0;
        dump_done = 1'b0;
    endfunction

    function automatic void end_test();
        if (!prefix_ok && rx_cnt != exp_q.size()) begin
            report_error($sformatf("received %0d characters, expected %0d",
                                   rx_cnt, exp_q.size()));
        end
        if (test_errs == 0) begin
            $display("test %s: ok, %0d characters", test_name, rx_cnt);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, test_errs);
            n_fail++;
        end
        exp_q.delete();
        active    = 1'b0;
        dump_done = 1'b0;
        test_name = "none";
    endfunction

    // sample in mid-cycle while tx is stable before the transferring edge
    always @(negedge MCLK) begin
        if (send_boot || send_user) begin
            rel_cycles = 0;
        end else if (rel_cycles < 4) begin
            rel_cycles++;
        end
        if (rel_cycles == 4 && tx.valid) begin
            report_error("tx.valid still high 3 cycles after both requests were released");
        end
        if (stalled && tx.valid && tx.data != stall_data) begin
            report_error($sformatf("tx.data changed from 8'h%02h to 8'h%02h while stalled",
                                   stall_data, tx.data));
        end
        if (tx.valid && exp_q.size() == 0) begin
            report_error($sformatf("character 8'h%02h offered with no dump expected", tx.data));
        end else if (tx.valid && tx_ready) begin
            if (rx_cnt >= exp_q.size()) begin
                report_error($sformatf("extra character 8'h%02h after the dump", tx.data));
            end else if (tx.data != exp_q[rx_cnt]) begin
                report_error($sformatf("character %0d is 8'h%02h, expected 8'h%02h",
                                       rx_cnt, tx.data, exp_q[rx_cnt]));
            end
            rx_cnt++;
        end
        stalled    = tx.valid && !tx_ready;
        stall_data = tx.data;
        dump_done  = active && (rx_cnt == exp_q.size());
    end

endmodule

`default_nettype wire

//--- bench/tb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_top import usb_dump_pkg::*; ();

    localparam int LINE_CHARS   = 3 * BYTES_PER_LINE + 2;
    localparam int BOOT_CHARS   = BOOT_TITLE_LEN + BOOT_LINES * LINE_CHARS + 2;
    localparam int USER_CHARS   = USER_TITLE_LEN + 5 + USER_LINES * LINE_CHARS + 2;
    localparam int TOTAL_CHARS  = 3 * BOOT_CHARS + 2 * USER_CHARS;
    localparam int STALL_FACTOR = 2;                // random tx_ready is high half the time
    localparam int LIMIT_NS     = (4 * TOTAL_CHARS * STALL_FACTOR + BUF_BITS + 1000) * 4;

    logic              MCLK;
    logic              arst_n;
    logic              fifo_en;
    logic              send_boot;
    logic              send_user;
    logic [PAGE_W-1:0] rel_page;
    buf_wr_t           buf_wr;
    char_t             tx;
    logic              tx_ready = 1'b1;
    logic              random_ready = 1'b0;
    logic              dump_done;
    logic [31:0]       fill_rng = 32'hde3683ff;
    logic [31:0]       ready_rng = 32'hde3683ff;
    logic [7:0]        mem_copy [BUF_BYTES];        // what the buffer should hold

    tb_clock clk_gen (.MCLK, .arst_n);

    usb_dump_top uut (
        .MCLK, .arst_n, .fifo_en, .send_boot, .send_user, .rel_page, .buf_wr, .tx, .tx_ready
    );

    tb_checker chk (
        .MCLK, .send_boot, .send_user, .tx, .tx_ready, .ref_mem(mem_copy), .dump_done
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // mode is taken at the edge, the new level lands 1 ns later
    always @(posedge MCLK) begin
        if (random_ready) begin
            ready_rng = xorshift(ready_rng);
            tx_ready <= #1 ready_rng[9];
        end else begin
            tx_ready <= #1 1'b1;
        end
    end

    task automatic fill_buffer();
        for (int i = 0; i < BUF_BYTES; i++) begin
            fill_rng    = xorshift(fill_rng);
            mem_copy[i] = fill_rng[7:0];
            for (int b = 0; b < 8; b++) begin       // one bit per cycle starting at the LSB
                @(posedge MCLK);
                #1;
                buf_wr = '{en: 1'b1, addr: BIT_ADDR_W'(8 * i + b), data: fill_rng[b]};
            end
        end
        @(posedge MCLK);
        #1;
        buf_wr.en = 1'b0;
    endtask

    // hold the request until the whole dump is seen, then release it
    task automatic run_dump(input string name, input logic fen, input logic boot,
                            input logic user, input logic [PAGE_W-1:0] page, input logic rnd);
        @(posedge MCLK);
        #1;
        fifo_en      = fen;
        rel_page     = page;
        random_ready = rnd;
        chk.start_test(name, fen, boot, user, page, 1'b0);
        send_boot = boot;
        send_user = user;
        wait (dump_done);
        repeat (20) @(posedge MCLK);                // no stray characters while held
        #1;
        send_boot = 1'b0;
        send_user = 1'b0;
        repeat (6) @(posedge MCLK);
        chk.end_test();
    endtask

    task automatic run_abort(input int cut);
        @(posedge MCLK);
        #1;
        fifo_en      = 1'b1;
        random_ready = 1'b1;
        chk.start_test("abort mid-dump", 1'b1, 1'b1, 1'b0, rel_page, 1'b1);
        send_boot = 1'b1;
        wait (chk.rx_cnt >= cut);
        @(posedge MCLK);
        #1;
        send_boot = 1'b0;
        repeat (6) @(posedge MCLK);
        chk.end_test();
    endtask

    initial begin
        #(LIMIT_NS);
        $display("timeout: the tests did not finish within %0d ns", LIMIT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        fifo_en   = 1'b0;
        send_boot = 1'b0;
        send_user = 1'b0;
        rel_page  = '0;
        buf_wr    = '0;
        wait (arst_n);
        fill_buffer();
        run_dump("idle after reset", 1'b1, 1'b0, 1'b0, 12'h000, 1'b0);
        run_dump("boot dump", 1'b1, 1'b1, 1'b0, 12'h000, 1'b0);
        run_dump("user dump with random tx_ready", 1'b1, 1'b0, 1'b1, 12'hA5C, 1'b1);
        run_dump("boot wins over user", 1'b1, 1'b1, 1'b1, 12'h3F1, 1'b1);
        run_dump("fifo_en low", 1'b0, 1'b1, 1'b0, 12'h000, 1'b0);
        run_abort(100);
        run_dump("user dump after abort", 1'b1, 1'b0, 1'b1, 12'h7E2, 1'b1);
        $display("%0d tests passed, %0d failed, %0d errors",
                 chk.n_pass, chk.n_fail, chk.total_errs);
        if (chk.n_fail == 0 && chk.total_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
design/usb_dump_pkg.sv
design/page_bit_buffer.sv
design/text_rom.sv
design/dump_sequencer.sv
design/fifo_tx_queue.sv
design/usb_dump_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_top -f compile.f -o tb_sim
out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'PASS: all tests'
